//--- vid_cfg_stim.txt
# Tags: B first-flag host-word | A aspect-x aspect-y | S width height
# W hmin hmax vmin vmax. All fields hex
# Reset defaults, 1920x1080 with no aspect
S 780 438
W 000 77f 000 437
# Display timing 1280x720, porch words and one word past the frame
B 1 0020
B 0 0500
B 0 006e
B 0 0028
B 0 00dc
B 0 02d0
B 0 0005
B 0 0005
B 0 0014
B 0 0bad
# Unknown opcode, parameters ignored
B 1 0055
B 0 0123
B 0 0456
# Limits 600 high and 1000 wide
B 1 0027
B 0 0258
B 1 0037
B 0 03e8
S 3e8 258
W 08c 473 03c 293
# Core aspect 4:3
A 0004 0003
S 3e8 258
W 0f0 40f 03c 293
# Custom aspects 16:9 and a literal 640x480
B 1 003a
B 0 0010
B 0 0009
B 0 1280
B 0 11e0
A 0001 0000
W 08c 473 04f 280
A 0002 0000
W 140 3bf 078 257
# Literal 800x400 on the core input
A 1320 1190
W 0f0 40f 0a0 22f
# Free scale over a 4:3 core aspect
A 0004 0003
B 1 0037
B 0 83e8
S 3e8 258
W 08c 473 03c 293

//--- all.f
+incdir+.
vid_cfg_pkg.sv
host_cmd_decoder.sv
umuldiv.sv
aspect_window_calc.sv
vid_cfg_top.sv
tb_vid_cfg.sv

//--- Bender.yml
package:
  name: vid_cfg

export_include_dirs:
  - .

sources:
  - vid_cfg_pkg.sv
  - host_cmd_decoder.sv
  - umuldiv.sv
  - aspect_window_calc.sv
  - vid_cfg_top.sv
  - target: test
    files:
      - tb_vid_cfg.sv

//--- tb_vid_cfg.sv
`timescale 1ns/100ps

//////////////////////////////////////////////////////////////////////
// Video window configuration testbench
// Replays host beats and aspect inputs from the stimulus file and
// checks the output size and window against the expected records
//////////////////////////////////////////////////////////////////////

`include "vid_cfg_defs.svh"

module tb_vid_cfg;

	localparam logic [7:0] TAG_BEAT   = "B";
	localparam logic [7:0] TAG_ASPECT = "A";
	localparam logic [7:0] TAG_SIZE   = "S";
	localparam logic [7:0] TAG_WINDOW = "W";

	typedef struct packed {
		logic [7:0]  kind;
		logic [15:0] f0;
		logic [15:0] f1;
		logic [15:0] f2;
		logic [15:0] f3;
	} stim_rec_t;

	logic                     clk_sys;
	logic                     resetd;
	vid_cfg_pkg::host_beat_t  host_beat;
	logic                     host_valid;
	logic                     host_ready;
	vid_cfg_pkg::ar_pair_t    core_ar;
	vid_cfg_pkg::disp_size_t  out_size;
	vid_cfg_pkg::window_t     window;
	logic                     win_valid;

	stim_rec_t recs[$];
	int        test_count;
	int        error_count;
	int        beats_taken;
	int        pacing_errors;
	int        cycle_count;
	int        cycle_limit;
	logic      accept_prev;
	logic      win_prev;

	vid_cfg_top UUT (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_host       (host_beat),
		.i_host_valid (host_valid),
		.o_host_ready (host_ready),
		.i_ar         (core_ar),
		.o_out_size   (out_size),
		.o_window     (window),
		.o_win_valid  (win_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////////////////////////

	// Handshake and window strobe are stable at the falling edge
	always @(negedge clk_sys) begin
		if (resetd) begin
			if (host_ready !== 1'b0 || win_valid !== 1'b0) begin
				error_count = error_count + 1;
				$display("Host ready or window valid was high during reset at cycle %0d",
					cycle_count);
			end
		end else begin
			if (host_valid && host_ready) begin
				beats_taken = beats_taken + 1;
				if (accept_prev) begin
					pacing_errors = pacing_errors + 1;
					$display("Two host beats were accepted in consecutive cycles at cycle %0d",
						cycle_count);
				end
			end
			if (win_valid && win_prev) begin
				error_count = error_count + 1;
				$display("Window valid stayed high for more than one cycle at cycle %0d",
					cycle_count);
			end
		end
		accept_prev = host_valid && host_ready;
		win_prev    = (win_valid === 1'b1);
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Back to the drive point, 1 ns after a rising edge
	task automatic next_slot();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic load_stim(output logic ok);
		int          fd;
		int          code;
		int          n;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] d;
		stim_rec_t   rec;
		ok = 1'b1;
		fd = $fopen("vid_cfg_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file vid_cfg_stim.txt");
			ok = 1'b0;
		end else begin
			code = $fgetc(fd);
			while (code != -1 && ok) begin
				if (code == "#") begin
					// Comment runs to the end of the line
					while (code != -1 && code != "\n") code = $fgetc(fd);
				end else if (code == "B" || code == "A" || code == "S") begin
					n = $fscanf(fd, " %h %h", a, b);
					rec = '{kind: code[7:0], f0: a, f1: b, f2: 16'h0, f3: 16'h0};
					if (n != 2) ok = 1'b0;
					recs.push_back(rec);
				end else if (code == "W") begin
					n = $fscanf(fd, " %h %h %h %h", a, b, c, d);
					rec = '{kind: code[7:0], f0: a, f1: b, f2: c, f3: d};
					if (n != 4) ok = 1'b0;
					recs.push_back(rec);
				end else if (code != " " && code != "\n" && code != "\r" && code != "\t") begin
					ok = 1'b0;
				end
				if (!ok) $display("Malformed record %0d in the stimulus file", recs.size());
				code = $fgetc(fd);
			end
			$fclose(fd);
		end
		if (!ok) error_count = error_count + 1;
	endtask

	// The ready rule allows at most one stalled cycle per beat
	task automatic send_beat(input vid_cfg_pkg::host_beat_t beat);
		logic taken;
		int   stalls;
		taken      = 1'b0;
		stalls     = 0;
		host_beat  = beat;
		host_valid = 1'b1;
		while (!taken) begin
			// Ready holds until the next edge samples it
			taken = host_ready;
			if (!taken) begin
				stalls = stalls + 1;
			end
			next_slot();
		end
		host_valid = 1'b0;
		if (stalls > 1) begin
			pacing_errors = pacing_errors + 1;
			$display("Host word %h waited %0d cycles for ready", beat.word.raw, stalls);
		end
	endtask

	// Counting starts one edge late so a pass begun before the change is skipped
	task automatic wait_win_pulses(input int count);
		int seen;
		seen = 0;
		next_slot();
		while (seen < count) begin
			@(negedge clk_sys);
			if (win_valid) seen = seen + 1;
		end
	endtask

	task automatic check_size(input vid_cfg_pkg::disp_size_t got,
		input vid_cfg_pkg::disp_size_t exp);
		test_count = test_count + 1;
		if (got !== exp) begin
			error_count = error_count + 1;
			$display("[ERROR] test %0d o_out_size: got %h x %h, expected %h x %h",
				test_count, got.width, got.height, exp.width, exp.height);
		end else begin
			$display("test %0d o_out_size %h x %h ok", test_count, got.width, got.height);
		end
	endtask

	task automatic check_window(input vid_cfg_pkg::window_t got,
		input vid_cfg_pkg::window_t exp);
		test_count = test_count + 1;
		if (got !== exp) begin
			error_count = error_count + 1;
			$display("[ERROR] test %0d o_window: got %h/%h/%h/%h, expected %h/%h/%h/%h",
				test_count, got.hmin, got.hmax, got.vmin, got.vmax,
				exp.hmin, exp.hmax, exp.vmin, exp.vmax);
		end else begin
			$display("test %0d o_window %h/%h/%h/%h ok", test_count,
				got.hmin, got.hmax, got.vmin, got.vmax);
		end
	endtask

	task automatic finish_run();
		$display("%0d tests run, %0d errors", test_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic                    loaded;
		int                      idle;
		stim_rec_t               rec;
		vid_cfg_pkg::host_beat_t beat;
		vid_cfg_pkg::disp_size_t exp_size;
		vid_cfg_pkg::window_t    exp_win;
		resetd         = 1'b1;
		host_beat      = '0;
		host_valid     = 1'b0;
		core_ar        = '0;
		test_count     = 0;
		error_count    = 0;
		beats_taken    = 0;
		pacing_errors  = 0;
		cycle_count    = 0;
		cycle_limit    = 0;
		accept_prev    = 1'b0;
		win_prev       = 1'b0;
		void'($urandom(32'he738));

		load_stim(loaded);
		cycle_limit = recs.size() * 200;

		repeat (10) @(posedge clk_sys);
		#1;
		resetd = 1'b0;

		if (loaded) begin
			foreach (recs[i]) begin
				rec = recs[i];
				case (rec.kind)
					TAG_BEAT: begin
						beat.first    = rec.f0[0];
						beat.word.raw = rec.f1;
						send_beat(beat);
						idle = $urandom % 4;
						repeat (idle) next_slot();
					end
					TAG_ASPECT: begin
						core_ar.x = rec.f0[`VC_AR_W-1:0];
						core_ar.y = rec.f1[`VC_AR_W-1:0];
					end
					TAG_SIZE: begin
						exp_size.width  = rec.f0[`VC_DIM_W-1:0];
						exp_size.height = rec.f1[`VC_DIM_W-1:0];
						wait_win_pulses(2);
						check_size(out_size, exp_size);
						next_slot();
					end
					default: begin
						exp_win.hmin = rec.f0[`VC_DIM_W-1:0];
						exp_win.hmax = rec.f1[`VC_DIM_W-1:0];
						exp_win.vmin = rec.f2[`VC_DIM_W-1:0];
						exp_win.vmax = rec.f3[`VC_DIM_W-1:0];
						wait_win_pulses(2);
						check_window(window, exp_win);
						next_slot();
					end
				endcase
			end

			test_count = test_count + 1;
			if (pacing_errors != 0) begin
				error_count = error_count + 1;
				$display("test %0d host pacing failed: %0d pacing errors over %0d beats",
					test_count, pacing_errors, beats_taken);
			end else begin
				$display("test %0d host pacing: %0d beats ok", test_count, beats_taken);
			end
		end

		finish_run();
	end

endmodule

//--- vid_cfg_top.sv
`timescale 1ns/100ps

//////////////////////////////////////////////////////////////////////
// Video window configuration top level
// Host command decoder feeding the aspect window calculator
//////////////////////////////////////////////////////////////////////

module vid_cfg_top (
	input  logic                    clk_sys,
	input  logic                    resetd,

	// Host word stream
	input  vid_cfg_pkg::host_beat_t i_host,
	input  logic                    i_host_valid,
	output logic                    o_host_ready,

	// Core aspect ratio
	input  vid_cfg_pkg::ar_pair_t   i_ar,

	output vid_cfg_pkg::disp_size_t o_out_size,
	output vid_cfg_pkg::window_t    o_window,
	output logic                    o_win_valid
);

	vid_cfg_pkg::disp_size_t  timing;
	vid_cfg_pkg::scale_ctrl_t scale;
	vid_cfg_pkg::custom_ar_t  arc;

	host_cmd_decoder u_decoder (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_host       (i_host),
		.i_host_valid (i_host_valid),
		.o_host_ready (o_host_ready),
		.o_timing     (timing),
		.o_scale      (scale),
		.o_arc        (arc)
	);

	aspect_window_calc u_calc (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_timing    (timing),
		.i_scale     (scale),
		.i_arc       (arc),
		.i_ar        (i_ar),
		.o_out_size  (o_out_size),
		.o_window    (o_window),
		.o_win_valid (o_win_valid)
	);

endmodule

//--- aspect_window_calc.sv
`timescale 1ns/100ps

//////////////////////////////////////////////////////////////////////
// Aspect window calculator
// Output size from the limits, then the video size from the aspect
// pair, centred in the display timing
//////////////////////////////////////////////////////////////////////

`include "vid_cfg_defs.svh"

module aspect_window_calc (
	input  logic                     clk_sys,
	input  logic                     resetd,

	input  vid_cfg_pkg::disp_size_t  i_timing,
	input  vid_cfg_pkg::scale_ctrl_t i_scale,
	input  vid_cfg_pkg::custom_ar_t  i_arc,
	input  vid_cfg_pkg::ar_pair_t    i_ar,

	output vid_cfg_pkg::disp_size_t  o_out_size,
	output vid_cfg_pkg::window_t     o_window,
	output logic                     o_win_valid
);

	localparam logic [2:0] S_START  = 3'd0;
	localparam logic [2:0] S_MD_W   = 3'd1;
	localparam logic [2:0] S_WAIT_W = 3'd2;
	localparam logic [2:0] S_MD_H   = 3'd3;
	localparam logic [2:0] S_WAIT_H = 3'd4;
	localparam logic [2:0] S_CLAMP  = 3'd5;
	localparam logic [2:0] S_CENTRE = 3'd6;
	localparam logic [2:0] S_WRITE  = 3'd7;

	vid_cfg_pkg::ar_pair_t eff_ar;
	logic                  eff_lit;
	logic                  use_out;
	logic [2:0]            state;
	logic                  md_start;
	logic                  md_busy;
	logic                  md_done;
	logic [`VC_DIM_W-1:0]  md_mul1;
	logic [`VC_DIM_W-1:0]  md_mul2;
	logic [`VC_DIM_W-1:0]  md_div;
	logic [`VC_DIM_W-1:0]  md_res;
	logic [`VC_DIM_W-1:0]  wcalc;
	logic [`VC_DIM_W-1:0]  hcalc;
	logic [`VC_DIM_W-1:0]  videow;
	logic [`VC_DIM_W-1:0]  videoh;
	logic [`VC_DIM_W-1:0]  hoff;
	logic [`VC_DIM_W-1:0]  voff;

	assign eff_lit = eff_ar.x[`VC_AR_W-1] | eff_ar.y[`VC_AR_W-1];
	assign use_out = i_scale.freescale | (eff_ar.x == '0) | (eff_ar.y == '0);
	assign md_done = ~md_start & ~md_busy;

	umuldiv #(
		.MUL_W (`VC_DIM_W),
		.DIV_W (`VC_DIM_W)
	) u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	// Output size limits and aspect pair selection, every cycle
	always_ff @(posedge clk_sys) begin
		o_out_size.width  <= ((i_scale.hset != '0) && (i_scale.hset < i_timing.width)) ?
			i_scale.hset : i_timing.width;
		o_out_size.height <= ((i_scale.vset != '0) && (i_scale.vset < i_timing.height)) ?
			i_scale.vset : i_timing.height;

		if (i_ar.y != '0) begin
			eff_ar <= i_ar;
		end else if (i_ar.x == `VC_AR_W'(1)) begin
			eff_ar <= i_arc.arc1;
		end else if (i_ar.x == `VC_AR_W'(2)) begin
			eff_ar <= i_arc.arc2;
		end else begin
			eff_ar <= '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state       <= S_START;
			md_start    <= 1'b0;
			o_win_valid <= 1'b0;
		end else begin
			md_start    <= 1'b0;
			o_win_valid <= 1'b0;
			case (state)
				S_START:  state <= (use_out || eff_lit) ? S_CLAMP : S_MD_W;
				S_MD_W: begin
					if (!md_busy) begin
						md_start <= 1'b1;
						state    <= S_WAIT_W;
					end
				end
				S_WAIT_W: if (md_done) state <= S_MD_H;
				S_MD_H: begin
					if (!md_busy) begin
						md_start <= 1'b1;
						state    <= S_WAIT_H;
					end
				end
				S_WAIT_H: if (md_done) state <= S_CLAMP;
				S_CLAMP:  state <= S_CENTRE;
				S_CENTRE: state <= S_WRITE;
				default: begin
					o_win_valid <= 1'b1;
					state       <= S_START;
				end
			endcase
		end
	end

	// Datapath, follows the sequencer state
	always_ff @(posedge clk_sys) begin
		case (state)
			S_START: begin
				// Literal size taken as is when no aspect math is needed
				wcalc <= use_out ? o_out_size.width  : eff_ar.x[`VC_DIM_W-1:0];
				hcalc <= use_out ? o_out_size.height : eff_ar.y[`VC_DIM_W-1:0];
			end
			// Width from height*x/y
			S_MD_W: begin
				md_mul1 <= o_out_size.height;
				md_mul2 <= eff_ar.x[`VC_DIM_W-1:0];
				md_div  <= eff_ar.y[`VC_DIM_W-1:0];
			end
			S_WAIT_W: if (md_done) wcalc <= md_res;
			// Height from width*y/x
			S_MD_H: begin
				md_mul1 <= o_out_size.width;
				md_mul2 <= eff_ar.y[`VC_DIM_W-1:0];
				md_div  <= eff_ar.x[`VC_DIM_W-1:0];
			end
			S_WAIT_H: if (md_done) hcalc <= md_res;
			S_CLAMP: begin
				videow <= (wcalc > o_out_size.width)  ? o_out_size.width  : wcalc;
				videoh <= (hcalc > o_out_size.height) ? o_out_size.height : hcalc;
			end
			S_CENTRE: begin
				hoff <= (i_timing.width  - videow) >> 1;
				voff <= (i_timing.height - videoh) >> 1;
			end
			default: begin
				o_window.hmin <= hoff;
				o_window.hmax <= hoff + videow - 1'b1;
				o_window.vmin <= voff;
				o_window.vmax <= voff + videoh - 1'b1;
			end
		endcase
	end

endmodule

//--- umuldiv.sv
`timescale 1ns/100ps

//////////////////////////////////////////////////////////////////////
// Serial unsigned multiply-then-divide
// floor(mul1*mul2/div) truncated to MUL_W bits, one bit per cycle
//////////////////////////////////////////////////////////////////////

module umuldiv #(
	parameter int MUL_W = 12,
	parameter int DIV_W = 12
) (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_start,
	input  logic [MUL_W-1:0] i_mul1,
	input  logic [MUL_W-1:0] i_mul2,
	input  logic [DIV_W-1:0] i_div,
	output logic             o_busy,
	output logic [MUL_W-1:0] o_result
);

	localparam int PW = MUL_W + DIV_W;
	localparam int SW = $clog2(MUL_W) + 1;

	localparam logic [1:0] PH_IDLE = 2'd0;
	localparam logic [1:0] PH_MUL  = 2'd1;
	localparam logic [1:0] PH_LOAD = 2'd2;
	localparam logic [1:0] PH_DIV  = 2'd3;

	logic [1:0]       phase;
	logic [SW-1:0]    step;
	logic             last_step;
	logic [MUL_W-1:0] mcand;
	logic [MUL_W-1:0] mplier;
	logic [DIV_W-1:0] divisor;
	logic [PW:0]      modulus;
	logic [PW:0]      acc;
	logic [PW:0]      acc_dbl;
	logic [PW:0]      acc_red;
	logic [PW:0]      acc_add;
	logic [PW:0]      acc_next;
	logic [DIV_W-1:0] rem;
	logic [MUL_W-1:0] quo;
	logic [DIV_W:0]   rem_sh;
	logic [DIV_W:0]   rem_sub;
	logic             rem_ge;

	assign o_busy    = (phase != PH_IDLE);
	assign o_result  = quo;
	assign last_step = (step == SW'(MUL_W - 1));

	// Product kept below div<<MUL_W, so the low quotient bits stay exact
	assign modulus  = {1'b0, divisor, {MUL_W{1'b0}}};
	assign acc_dbl  = {acc[PW-1:0], 1'b0};
	assign acc_red  = (acc_dbl >= modulus) ? acc_dbl - modulus : acc_dbl;
	assign acc_add  = acc_red + {{(DIV_W + 1){1'b0}}, mcand & {MUL_W{mplier[MUL_W-1]}}};
	assign acc_next = (acc_add >= modulus) ? acc_add - modulus : acc_add;

	// Restoring division step
	assign rem_sh  = {rem, quo[MUL_W-1]};
	assign rem_sub = rem_sh - {1'b0, divisor};
	assign rem_ge  = (rem_sh >= {1'b0, divisor});

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			phase <= PH_IDLE;
			step  <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					step <= '0;
					if (i_start) begin
						phase <= PH_MUL;
					end
				end
				PH_MUL: begin
					step <= step + 1'b1;
					if (last_step) begin
						phase <= PH_LOAD;
					end
				end
				PH_LOAD: begin
					step  <= '0;
					phase <= PH_DIV;
				end
				default: begin
					step <= step + 1'b1;
					if (last_step) begin
						phase <= PH_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		case (phase)
			PH_IDLE: begin
				if (i_start) begin
					mcand   <= i_mul1;
					mplier  <= i_mul2;
					divisor <= i_div;
					acc     <= '0;
				end
			end
			// Multiplier bits MSB first
			PH_MUL: begin
				acc    <= acc_next;
				mplier <= mplier << 1;
			end
			PH_LOAD: begin
				rem <= acc[PW-1:MUL_W];
				quo <= acc[MUL_W-1:0];
			end
			// Dividend bits shift out as quotient bits shift in
			default: begin
				rem <= rem_ge ? rem_sub[DIV_W-1:0] : rem_sh[DIV_W-1:0];
				quo <= (quo << 1) | MUL_W'(rem_ge);
			end
		endcase
	end

endmodule

//--- host_cmd_decoder.sv
`timescale 1ns/100ps

//////////////////////////////////////////////////////////////////////
// Host command decoder
// Takes host word beats and keeps the display timing, output limit
// and custom aspect registers
//////////////////////////////////////////////////////////////////////

`include "vid_cfg_defs.svh"

module host_cmd_decoder (
	input  logic                     clk_sys,
	input  logic                     resetd,

	input  vid_cfg_pkg::host_beat_t  i_host,
	input  logic                     i_host_valid,
	output logic                     o_host_ready,

	output vid_cfg_pkg::disp_size_t  o_timing,
	output vid_cfg_pkg::scale_ctrl_t o_scale,
	output vid_cfg_pkg::custom_ar_t  o_arc
);

	// Counter saturates well past the longest frame that is decoded
	localparam int CNT_W = 4;

	logic             ready_r;
	logic             accept;
	logic             param_beat;
	logic [7:0]       cmd;
	logic [CNT_W-1:0] cnt;

	assign accept       = i_host_valid & ready_r;
	assign param_beat   = accept & ~i_host.first;
	assign o_host_ready = ready_r;

	//////////////////////////////////////////////////////////////////////
	// Beat pacing
	//////////////////////////////////////////////////////////////////////

	// One idle cycle after every accepted word
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			ready_r <= 1'b0;
		end else begin
			ready_r <= ~accept;
		end
	end

	// Opcode and parameter index of the frame in progress
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cmd <= 8'h00;
			cnt <= '0;
		end else if (accept) begin
			if (i_host.first) begin
				cmd <= i_host.word.cmd.opcode;
				cnt <= '0;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Configuration registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_timing.width  <= `VC_RESET_WIDTH;
			o_timing.height <= `VC_RESET_HEIGHT;
			o_scale         <= '0;
			o_arc           <= '0;
		end else if (param_beat) begin
			case (cmd)
				`VC_CMD_TIMING: begin
					// Porch and sync words pass through unused
					if (cnt < CNT_W'(`VC_TIMING_WORDS)) begin
						case (cnt)
							CNT_W'(0): o_timing.width  <= i_host.word.raw[`VC_DIM_W-1:0];
							CNT_W'(4): o_timing.height <= i_host.word.raw[`VC_DIM_W-1:0];
							default: ;
						endcase
					end
				end

				`VC_CMD_VSET: begin
					o_scale.vset <= i_host.word.scale.limit;
				end

				`VC_CMD_HSET: begin
					o_scale.hset      <= i_host.word.scale.limit;
					o_scale.freescale <= i_host.word.scale.freescale;
				end

				`VC_CMD_ARC: begin
					case (cnt)
						CNT_W'(0): o_arc.arc1.x <= i_host.word.raw[`VC_AR_W-1:0];
						CNT_W'(1): o_arc.arc1.y <= i_host.word.raw[`VC_AR_W-1:0];
						CNT_W'(2): o_arc.arc2.x <= i_host.word.raw[`VC_AR_W-1:0];
						CNT_W'(3): o_arc.arc2.y <= i_host.word.raw[`VC_AR_W-1:0];
						default: ;
					endcase
				end

				// Unknown opcodes
				default: ;
			endcase
		end
	end

endmodule

//--- vid_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Video window configuration types
// Host word views and the configuration and window records
//////////////////////////////////////////////////////////////////////

`include "vid_cfg_defs.svh"

package vid_cfg_pkg;

	// First word of a frame
	typedef struct packed {
		logic [`VC_DATA_W-9:0]          spare;
		logic [7:0]                     opcode;
	} host_cmd_word_t;

	// Limit word of the 0x27 and 0x37 commands
	typedef struct packed {
		logic                           freescale;
		logic [`VC_DATA_W-`VC_DIM_W-2:0] spare;
		logic [`VC_DIM_W-1:0]           limit;
	} host_scale_word_t;

	typedef union packed {
		host_cmd_word_t                 cmd;
		host_scale_word_t               scale;
		logic [`VC_DATA_W-1:0]          raw;
	} host_word_u;

	typedef struct packed {
		logic                           first;
		host_word_u                     word;
	} host_beat_t;

	typedef struct packed {
		logic [`VC_DIM_W-1:0]           width;
		logic [`VC_DIM_W-1:0]           height;
	} disp_size_t;

	typedef struct packed {
		logic [`VC_DIM_W-1:0]           hset;
		logic [`VC_DIM_W-1:0]           vset;
		logic                           freescale;
	} scale_ctrl_t;

	typedef struct packed {
		logic [`VC_AR_W-1:0]            x;
		logic [`VC_AR_W-1:0]            y;
	} ar_pair_t;

	typedef struct packed {
		ar_pair_t                       arc1;
		ar_pair_t                       arc2;
	} custom_ar_t;

	typedef struct packed {
		logic [`VC_DIM_W-1:0]           hmin;
		logic [`VC_DIM_W-1:0]           hmax;
		logic [`VC_DIM_W-1:0]           vmin;
		logic [`VC_DIM_W-1:0]           vmax;
	} window_t;

endpackage

//--- vid_cfg_defs.svh
//////////////////////////////////////////////////////////////////////
// Video window configuration constants
// Field widths, host command opcodes and the display timing at reset
//////////////////////////////////////////////////////////////////////

`ifndef VID_CFG_DEFS_SVH
`define VID_CFG_DEFS_SVH

// Field widths
`define VC_DATA_W        16
`define VC_DIM_W         12
// Top bit of an aspect component marks a literal pixel size
`define VC_AR_W          13

// Host command opcodes
`define VC_CMD_TIMING    8'h20
`define VC_CMD_VSET      8'h27
`define VC_CMD_HSET      8'h37
`define VC_CMD_ARC       8'h3A

// Parameter words in a display timing frame
`define VC_TIMING_WORDS  8

// Display timing after reset, 1080p
`define VC_RESET_WIDTH   12'd1920
`define VC_RESET_HEIGHT  12'd1080

`endif
